// File: dekatronPkg.sv
package dekatronPkg;

	// Digit layout of the counter.
	localparam int digitCount = 3;
	localparam int digitWidth = 4;

	// One decade digit, held in BCD.
	typedef logic [digitWidth-1:0] digitT;

	// Whole count, lowest digit in the low nibble.
	typedef logic [digitCount*digitWidth-1:0] countT;

	// Largest value the counter reaches before wrapping.
	localparam countT topValue = 12'h255;

	// Largest value a single digit may hold.
	localparam digitT digitMax = 4'd9;

	// Tube settling time, counted in Clk cycles.
	localparam int settleCycles = 3;

	// Settle down-counter, wide enough for settleCycles.
	typedef logic [1:0] settleT;

endpackage

// File: commandPkg.sv
package commandPkg;

	// Command opcodes at the counter input.
	typedef enum logic [1:0] {
		opInc,   // Count up by one.
		opDec,   // Count down by one.
		opSet,   // Load cmdValue.
		opClear  // Load zero.
	} opT;

	// Queue entries, and credits the sender owns after reset.
	localparam int queueDepth = 4;

	// Read and write pointers.
	typedef logic [1:0] queueIndexT;

	// Fill level, 0 up to queueDepth inclusive.
	typedef logic [2:0] queueCountT;

endpackage

// File: digitBankIf.sv
`timescale 1ns/1ps

interface digitBankIf;

	// Requests from the control FSM.
	logic stepUp;                    // Single pulse into the lowest digit.
	logic stepDown;
	logic load;                      // Parallel load of every digit.
	dekatronPkg::countT loadValue;

	// Status returned by the digit bank.
	logic busy;                      // A digit is settling or a carry is in flight.
	logic atZero;
	logic atTop;
	dekatronPkg::countT count;

	modport control (
		output stepUp,
		output stepDown,
		output load,
		output loadValue,
		input  busy,
		input  atZero,
		input  atTop
	);

	modport bank (
		input  stepUp,
		input  stepDown,
		input  load,
		input  loadValue,
		output busy,
		output atZero,
		output atTop,
		output count
	);

endinterface

// File: commandQueue.sv
`timescale 1ns/1ps

module commandQueue (
	input  logic                Clk,
	input  logic                Rst_n,
	input  logic                cmdValid,
	input  commandPkg::opT      cmdOp,
	input  dekatronPkg::countT  cmdValue,
	input  logic                pop,
	output commandPkg::opT      headOp,
	output dekatronPkg::countT  headValue,
	output logic                notEmpty,
	output logic                creditReturn
);

	commandPkg::opT opMem [commandPkg::queueDepth];
	dekatronPkg::countT valueMem [commandPkg::queueDepth];

	commandPkg::queueIndexT wrPtr;
	commandPkg::queueIndexT rdPtr;
	commandPkg::queueCountT occupancy;

	// Entry storage.
	always_ff @(posedge Clk) begin
		if (cmdValid) begin
			opMem[wrPtr] <= cmdOp;
			valueMem[wrPtr] <= cmdValue;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			wrPtr <= '0;
			rdPtr <= '0;
			occupancy <= '0;
		end else begin
			if (cmdValid)
				wrPtr <= wrPtr + 1'b1;  // Pointers wrap with the depth.
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({cmdValid, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;  // Both or neither.
			endcase
		end
	end

	assign headOp = opMem[rdPtr];
	assign headValue = valueMem[rdPtr];
	assign notEmpty = (occupancy != '0);

	// Every popped entry frees one slot at the sender.
	assign creditReturn = pop;

	// Credits held by the sender never exceed the free slots.
	assert property (@(posedge Clk) disable iff (!Rst_n)
		cmdValid |-> (occupancy != commandPkg::queueCountT'(commandPkg::queueDepth)))
		else $error("commandQueue: write while full");

	// The control FSM only pops a valid head.
	assert property (@(posedge Clk) disable iff (!Rst_n)
		pop |-> notEmpty)
		else $error("commandQueue: pop while empty");

endmodule

// File: counterControl.sv
`timescale 1ns/1ps

module counterControl (
	input  logic                Clk,
	input  logic                Rst_n,
	input  commandPkg::opT      headOp,
	input  dekatronPkg::countT  headValue,
	input  logic                notEmpty,
	output logic                pop,
	digitBankIf.control         bank,
	output logic                done
);

	typedef enum logic [1:0] {
		stIdle,
		stIssue,
		stWait
	} stateT;

	// What the bank is asked to do for the current command.
	typedef enum logic [1:0] {
		actStepUp,
		actStepDown,
		actLoad
	} actionT;

	stateT state;
	stateT nextState;
	actionT action;
	dekatronPkg::countT actValue;

	// Take a command only once the previous one has fully settled.
	assign pop = (state == stIdle) && notEmpty && !bank.busy;

	always_comb begin
		nextState = state;
		case (state)
			stIdle:  if (pop) nextState = stIssue;
			stIssue: nextState = stWait;
			stWait:  if (!bank.busy) nextState = stIdle;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= stIdle;
			action <= actStepUp;
		end else begin
			state <= nextState;
			if (pop) begin
				// Wrap decisions use the flags as they stand now.
				case (headOp)
					commandPkg::opInc: action <= bank.atTop ? actLoad : actStepUp;
					commandPkg::opDec: action <= bank.atZero ? actLoad : actStepDown;
					default: action <= actLoad;  // Set and clear.
				endcase
			end
		end
	end

	// Value used when the action turns out to be a load.
	always_ff @(posedge Clk) begin
		if (pop) begin
			case (headOp)
				commandPkg::opDec: actValue <= dekatronPkg::topValue;
				commandPkg::opSet: actValue <= headValue;
				default: actValue <= '0;  // Increment past top, or clear.
			endcase
		end
	end

	assign bank.stepUp = (state == stIssue) && (action == actStepUp);
	assign bank.stepDown = (state == stIssue) && (action == actStepDown);
	assign bank.load = (state == stIssue) && (action == actLoad);
	assign bank.loadValue = actValue;

	// Bank has gone quiet after the issued request.
	assign done = (state == stWait) && !bank.busy;

	// A request into a settling chain would be lost by the tubes.
	assert property (@(posedge Clk) disable iff (!Rst_n)
		(bank.stepUp || bank.stepDown || bank.load) |-> !bank.busy)
		else $error("counterControl: request while bank busy");

endmodule

// File: dekatronBank.sv
`timescale 1ns/1ps

module dekatronBank (
	input  logic        Clk,
	input  logic        Rst_n,
	digitBankIf.bank    bank
);

	localparam int digitCount = dekatronPkg::digitCount;
	localparam int digitWidth = dekatronPkg::digitWidth;

	dekatronPkg::digitT digits [digitCount];
	dekatronPkg::settleT settle [digitCount];
	logic [digitCount-1:0] wrapPending;  // Carry or borrow waiting for settle.
	logic [digitCount-1:0] wrapUp;       // High for carry, low for borrow.
	logic [digitCount-1:0] upIn;
	logic [digitCount-1:0] downIn;
	logic [digitCount-1:0] digitBusy;

	// Pulse sources: the interface for digit zero, the lower digit above that.
	always_comb begin
		upIn[0] = bank.stepUp;
		downIn[0] = bank.stepDown;
		for (int i = 1; i < digitCount; i++) begin
			// Fires in the last settle cycle so busy has no gap.
			upIn[i] = wrapPending[i-1] && wrapUp[i-1] && (settle[i-1] == 2'd1);
			downIn[i] = wrapPending[i-1] && !wrapUp[i-1] && (settle[i-1] == 2'd1);
		end
		for (int i = 0; i < digitCount; i++) begin
			digitBusy[i] = (settle[i] != '0);
			bank.count[i*digitWidth +: digitWidth] = digits[i];
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			for (int i = 0; i < digitCount; i++) begin
				digits[i] <= '0;
				settle[i] <= '0;
			end
			wrapPending <= '0;
			wrapUp <= '0;
		end else begin
			for (int i = 0; i < digitCount; i++) begin
				if (bank.load) begin
					digits[i] <= bank.loadValue[i*digitWidth +: digitWidth];
					settle[i] <= dekatronPkg::settleT'(dekatronPkg::settleCycles);
					wrapPending[i] <= 1'b0;
				end else if (upIn[i]) begin
					digits[i] <= (digits[i] == dekatronPkg::digitMax) ? '0 : digits[i] + 1'b1;
					settle[i] <= dekatronPkg::settleT'(dekatronPkg::settleCycles);
					wrapPending[i] <= (digits[i] == dekatronPkg::digitMax);
					wrapUp[i] <= 1'b1;
				end else if (downIn[i]) begin
					digits[i] <= (digits[i] == '0) ? dekatronPkg::digitMax : digits[i] - 1'b1;
					settle[i] <= dekatronPkg::settleT'(dekatronPkg::settleCycles);
					wrapPending[i] <= (digits[i] == '0);
					wrapUp[i] <= 1'b0;
				end else if (digitBusy[i]) begin
					settle[i] <= settle[i] - 1'b1;
					if (settle[i] == 2'd1)
						wrapPending[i] <= 1'b0;  // Handed to the next tube.
				end
			end
		end
	end

	assign bank.busy = |digitBusy;
	assign bank.atZero = (bank.count == '0);
	assign bank.atTop = (bank.count == dekatronPkg::topValue);

	// Loads and ripples must keep every tube on a decimal position.
	for (genvar g = 0; g < digitCount; g++) begin : gDigitCheck
		assert property (@(posedge Clk) disable iff (!Rst_n)
			digits[g] <= dekatronPkg::digitMax)
			else $error("dekatronBank: digit %0d out of range", g);
	end

endmodule

// File: dekatronCounter.sv
`timescale 1ns/1ps

module dekatronCounter (
	input  logic                Clk,
	input  logic                Rst_n,
	input  logic                cmdValid,
	input  commandPkg::opT      cmdOp,
	input  dekatronPkg::countT  cmdValue,
	output logic                creditReturn,
	output dekatronPkg::countT  count,
	output logic                zero,
	output logic                done
);

	commandPkg::opT headOp;
	dekatronPkg::countT headValue;
	logic notEmpty;
	logic pop;

	digitBankIf u_bankIf ();

	commandQueue u_queue (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.cmdValid     (cmdValid),
		.cmdOp        (cmdOp),
		.cmdValue     (cmdValue),
		.pop          (pop),
		.headOp       (headOp),
		.headValue    (headValue),
		.notEmpty     (notEmpty),
		.creditReturn (creditReturn)
	);

	counterControl u_control (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.headOp    (headOp),
		.headValue (headValue),
		.notEmpty  (notEmpty),
		.pop       (pop),
		.bank      (u_bankIf.control),
		.done      (done)
	);

	dekatronBank u_bank (
		.Clk   (Clk),
		.Rst_n (Rst_n),
		.bank  (u_bankIf.bank)
	);

	assign count = u_bankIf.count;  // Tube positions as BCD.
	assign zero = u_bankIf.atZero;

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
	input  logic                Clk,
	input  logic                Rst_n,
	input  logic                cmdValid,
	input  commandPkg::opT      cmdOp,
	input  dekatronPkg::countT  cmdValue,
	input  logic                creditReturn,
	input  dekatronPkg::countT  count,
	input  logic                zero,
	input  logic                done,
	output int                  errorCount,
	output int                  doneCount
);

	commandPkg::opT opQueue [$];        // Accepted and not yet completed.
	dekatronPkg::countT valueQueue [$];
	int modelValue;                     // Reference count as a plain integer.
	int resetCycles;
	int acceptCount;
	int returnCount;

	function automatic int bcdToInt(input dekatronPkg::countT bcd);
		return int'(bcd[11:8]) * 100 + int'(bcd[7:4]) * 10 + int'(bcd[3:0]);
	endfunction

	function automatic dekatronPkg::countT intToBcd(input int value);
		return {dekatronPkg::digitT'(value / 100), dekatronPkg::digitT'((value / 10) % 10),
			dekatronPkg::digitT'(value % 10)};
	endfunction

	// Counter behavior in top-limit mode.
	function automatic int nextValue(input commandPkg::opT op, input dekatronPkg::countT value,
			input int current);
		int topInt;
		topInt = bcdToInt(dekatronPkg::topValue);
		case (op)
			commandPkg::opInc: return (current == topInt) ? 0 : current + 1;
			commandPkg::opDec: return (current == 0) ? topInt : current - 1;
			commandPkg::opSet: return bcdToInt(value);
			default: return 0;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got %0h expected %0h", name, got, expected);
			errorCount++;
		end
	endtask

	initial errorCount = 0;

	always @(posedge Clk) begin
		if (!Rst_n) begin
			// First edge only settles the flops.
			if (resetCycles > 0) begin
				compareValue("done", 32'(done), 32'(1'b0));
				compareValue("creditReturn", 32'(creditReturn), 32'(1'b0));
				compareValue("count", 32'(count), 32'(0));
				compareValue("zero", 32'(zero), 32'(1'b1));
			end
			resetCycles++;
			modelValue = 0;
			acceptCount = 0;
			returnCount = 0;
			doneCount = 0;
			opQueue.delete();
			valueQueue.delete();
		end else begin
			if (creditReturn) begin
				returnCount++;
				if (returnCount > acceptCount) begin
					$display("credit returned with no command outstanding");
					errorCount++;
				end
			end
			if (done) begin
				if (opQueue.size() == 0) begin
					$display("done pulse with no command outstanding");
					errorCount++;
				end else begin
					modelValue = nextValue(opQueue.pop_front(), valueQueue.pop_front(),
						modelValue);
					doneCount++;
					compareValue("count", 32'(count), 32'(intToBcd(modelValue)));
					compareValue("zero", 32'(zero), 32'(modelValue == 0));
				end
			end
			if (cmdValid) begin
				opQueue.push_back(cmdOp);
				valueQueue.push_back(cmdValue);
				acceptCount++;
			end
		end
	end

endmodule

// File: tbDekatronCounter.sv
`timescale 1ns/1ps

module tbDekatronCounter;

	localparam int numCommands = 300;
	localparam int cycleLimit = numCommands * 20 + 200;

	logic Clk;
	logic Rst_n;
	logic cmdValid;
	commandPkg::opT cmdOp;
	dekatronPkg::countT cmdValue;
	logic creditReturn;
	dekatronPkg::countT count;
	logic zero;
	logic done;

	int checkerErrors;
	int doneCount;
	int stimulusErrors = 0;
	int cycleCount = 0;
	int credits;      // Sender side credit count.

	always #10 Clk = ~Clk;  // 20 ns period.

	dekatronCounter u_dekatronCounter (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.cmdValid     (cmdValid),
		.cmdOp        (cmdOp),
		.cmdValue     (cmdValue),
		.creditReturn (creditReturn),
		.count        (count),
		.zero         (zero),
		.done         (done)
	);

	tbChecker u_checker (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.cmdValid     (cmdValid),
		.cmdOp        (cmdOp),
		.cmdValue     (cmdValue),
		.creditReturn (creditReturn),
		.count        (count),
		.zero         (zero),
		.done         (done),
		.errorCount   (checkerErrors),
		.doneCount    (doneCount)
	);

	always @(posedge Clk) cycleCount <= cycleCount + 1;

	task automatic endRun(input bit timedOut);
		int total;
		total = checkerErrors + stimulusErrors + int'(timedOut);
		$display("errors: checker %0d, stimulus %0d, timeout %0d",
			checkerErrors, stimulusErrors, timedOut);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	// Inc and dec dominate, set values cluster near the carry and wrap points.
	task automatic driveRandomCommand();
		int opPick;
		int n;
		opPick = $urandom_range(0, 9);
		if (opPick < 4)
			cmdOp = commandPkg::opInc;
		else if (opPick < 8)
			cmdOp = commandPkg::opDec;
		else if (opPick == 8)
			cmdOp = commandPkg::opSet;
		else
			cmdOp = commandPkg::opClear;
		case ($urandom_range(0, 3))
			0: n = $urandom_range(0, 255);
			1: n = $urandom_range(250, 255);
			2: n = $urandom_range(0, 5);
			default: n = $urandom_range(95, 104);
		endcase
		cmdValue = {dekatronPkg::digitT'(n / 100), dekatronPkg::digitT'((n / 10) % 10),
			dekatronPkg::digitT'(n % 10)};
		cmdValid = 1'b1;
	endtask

	initial begin
		int sent;
		Clk = 1'b0;
		Rst_n = 1'b0;
		cmdValid = 1'b0;
		cmdOp = commandPkg::opInc;
		cmdValue = '0;
		sent = 0;
		void'($urandom(56));
		credits = commandPkg::queueDepth;
		repeat (10) @(posedge Clk);
		#1 Rst_n = 1'b1;
		while (sent < numCommands) begin
			@(posedge Clk);
			if (creditReturn)
				credits++;
			#1;
			if (credits > 0 && $urandom_range(0, 3) != 0) begin
				driveRandomCommand();
				credits--;
				sent++;
			end else begin
				cmdValid = 1'b0;  // Idle gap or out of credits.
			end
		end
		@(posedge Clk);
		if (creditReturn)
			credits++;
		#1 cmdValid = 1'b0;
		do begin
			@(posedge Clk);
			if (creditReturn)
				credits++;
			#1;
		end while (doneCount < numCommands);
		repeat (5) begin
			@(posedge Clk);
			if (creditReturn)
				credits++;
			#1;
		end
		if (credits != commandPkg::queueDepth) begin
			$display("credits not all returned: sender holds %0d of %0d",
				credits, commandPkg::queueDepth);
			stimulusErrors++;
		end
		endRun(1'b0);
	end

	// Watchdog on the cycle counter.
	initial begin
		while (cycleCount < cycleLimit)
			@(posedge Clk);
		$display("timeout: %0d of %0d commands completed within %0d cycles",
			doneCount, numCommands, cycleLimit);
		endRun(1'b1);
	end

endmodule

// File: list.f
dekatronPkg.sv
commandPkg.sv
digitBankIf.sv
commandQueue.sv
counterControl.sv
dekatronBank.sv
dekatronCounter.sv
tbChecker.sv
tbDekatronCounter.sv

// File: Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      ?= tbDekatronCounter
FILELIST ?= list.f
OBJDIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
